// ==== huff_pkg.sv ====
/*
 * Shared constants and the walker state type for the Huffman codebook builder.
 * Node words, child entries, code words and codebook sizes are all defined here.
 * Modules pull these in with a wildcard import in their header.
 */
`default_nettype none

package huff_pkg;

    localparam int NODE_AW    = 7;            // node index, up to 128 internal nodes
    localparam int NUM_NODES  = 1 << NODE_AW;
    localparam int CHAR_W     = 8;            // character width
    localparam int NUM_CHARS  = 1 << CHAR_W;  // codebook entries
    localparam int ENTRY_W    = 9;            // one child entry
    localparam int NODE_W     = 2 * ENTRY_W;  // left entry high, right entry low
    localparam int CODE_W     = 32;           // longest code, also code word width
    localparam int LEN_W      = 6;            // code length field

    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;            // pointer width, wraps at depth
    localparam int FIFO_CW    = 3;            // count has to reach FIFO_DEPTH

    // child entry layout inside a node word
    localparam int LEFT_LSB   = ENTRY_W;
    localparam int RIGHT_LSB  = 0;
    localparam int INT_BIT    = ENTRY_W - 1;  // set = internal node, clear = leaf

    typedef enum logic [2:0] {
        INIT,       // idle, waiting for start
        FETCH,      // one wait cycle for the node read
        LEFT,       // take the left child
        RIGHT,      // take the right child
        TRACK,      // re-walk from the root to reload a parent
        BACKTRACK,  // pop moves until a left move is found
        FINISH      // walk complete
    } cb_state_t;

endpackage

`default_nettype wire

// ==== htree_ram.sv ====
/*
 * Node memory for the Huffman tree.
 * Loaded through the external write port while the walker is idle.
 * The walker's node_index is read every cycle, and node_data follows one cycle later.
 */
`timescale 1ns/1ps
`default_nettype none

module htree_ram
    import huff_pkg::*;
(
    input  logic               clk,
    input  logic               tree_we,
    input  logic [NODE_AW-1:0] tree_waddr,
    input  logic [NODE_W-1:0]  tree_wdata,
    input  logic [NODE_AW-1:0] node_index,
    output logic [NODE_W-1:0]  node_data
);

    logic [NODE_W-1:0] mem [NUM_NODES];  // undefined until the tree is loaded

    always_ff @(posedge clk) begin
        if (tree_we) begin
            mem[tree_waddr] <= tree_wdata;  // external load
        end
        node_data <= mem[node_index];  // registered read, one cycle latency
    end

endmodule

`default_nettype wire

// ==== cb_synthesis.sv ====
/*
 * Tree walker. It goes depth first, left before right, from root_index.
 * The path register keeps a sentinel bit plus one bit per move, newest in bit 0.
 * Each leaf sends its character, code and length on a valid/ready stream.
 * After a leaf, BACKTRACK pops moves up to the last left move. TRACK then
 * re-walks from the root to reload the parent when the walker has left it.
 */
`timescale 1ns/1ps
`default_nettype none

module cb_synthesis
    import huff_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [NODE_AW-1:0] root_index,
    output logic [NODE_AW-1:0] node_index,
    input  logic [NODE_W-1:0]  node_data,
    output logic               code_valid,
    input  logic               code_ready,
    output logic [CHAR_W-1:0]  code_char,
    output logic [CODE_W-1:0]  code_bits,
    output logic [LEN_W-1:0]   code_len,
    output logic               busy,
    output logic               done,
    output logic               start_accept
);

    cb_state_t          state;
    cb_state_t          after_fetch;  // state entered once node_data is valid
    logic [CODE_W:0]    path;         // sentinel + moves
    logic [LEN_W-1:0]   track_len;    // moves held in path
    logic [LEN_W-1:0]   pos;          // re-walk position
    logic [NODE_AW-1:0] root_q;
    logic               moved;        // popped a right move, parent no longer loaded

    logic [LEN_W-1:0]   trk_bit;      // path bit for the next re-walk step
    logic               go_right;
    logic [ENTRY_W-1:0] child;
    logic [CODE_W:0]    ext_path;     // path with the current move appended
    logic [LEN_W-1:0]   ext_len;
    logic [CODE_W:0]    ext_code;     // ext_path without its sentinel

    assign start_accept = start && !busy;

    always_comb begin
        trk_bit  = track_len - pos - 1'b1;
        go_right = (state == RIGHT) || (state == TRACK && pos != track_len && path[trk_bit]);
        child    = go_right ? node_data[RIGHT_LSB +: ENTRY_W] : node_data[LEFT_LSB +: ENTRY_W];
        ext_path = {path[CODE_W-1:0], state == RIGHT};
        ext_len  = track_len + 1'b1;
        ext_code = ext_path & ~({{CODE_W{1'b0}}, 1'b1} << ext_len);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            after_fetch <= LEFT;
            node_index  <= '0;
            path        <= '0;
            track_len   <= '0;
            pos         <= '0;
            moved       <= 1'b0;
            code_valid  <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            if (code_valid && code_ready) begin
                code_valid <= 1'b0;  // taken by the FIFO
            end
            case (state)
                INIT: begin
                    if (start_accept) begin
                        root_q      <= root_index;
                        node_index  <= root_index;
                        path        <= {{CODE_W{1'b0}}, 1'b1};  // sentinel only
                        track_len   <= '0;
                        busy        <= 1'b1;
                        done        <= 1'b0;
                        after_fetch <= LEFT;
                        state       <= FETCH;
                    end
                end
                FETCH: begin
                    state <= after_fetch;  // node_data arrives at this edge
                end
                LEFT, RIGHT: begin
                    path      <= ext_path;
                    track_len <= ext_len;
                    if (child[INT_BIT]) begin  // internal, descend
                        node_index  <= child[NODE_AW-1:0];
                        after_fetch <= LEFT;
                        state       <= FETCH;
                    end else begin  // leaf, emit
                        code_valid <= 1'b1;
                        code_char  <= child[CHAR_W-1:0];
                        code_bits  <= ext_code[CODE_W-1:0];
                        code_len   <= ext_len;
                        moved      <= 1'b0;  // node_index still holds the leaf's parent
                        state      <= BACKTRACK;
                    end
                end
                TRACK: begin
                    if (pos == track_len) begin
                        state <= RIGHT;  // parent is loaded again
                    end else begin
                        node_index  <= child[NODE_AW-1:0];
                        pos         <= pos + 1'b1;
                        after_fetch <= TRACK;
                        state       <= FETCH;
                    end
                end
                BACKTRACK: begin
                    if (!code_valid || code_ready) begin  // stall until the code is taken
                        if (track_len == '0) begin
                            state <= FINISH;  // back at the sentinel
                        end else begin
                            path      <= path >> 1;
                            track_len <= track_len - 1'b1;
                            if (path[0]) begin
                                moved <= 1'b1;  // right move, keep popping
                            end else if (moved) begin
                                node_index  <= root_q;  // reload parent from the root
                                pos         <= '0;
                                after_fetch <= TRACK;
                                state       <= FETCH;
                            end else begin
                                state <= RIGHT;  // parent still in node_data
                            end
                        end
                    end
                end
                FINISH: begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= INIT;
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    a_len_max: assert property (@(posedge clk) disable iff (rst)
        code_valid |-> code_len <= CODE_W)
        else $error("code_len above CODE_W");

    // a stalled code must reach the FIFO unchanged
    a_code_hold: assert property (@(posedge clk) disable iff (rst)
        code_valid && !code_ready |=> code_valid && $stable(code_char)
            && $stable(code_bits) && $stable(code_len))
        else $error("code fields changed under back-pressure");

    // node_index only moves on the way into FETCH, never out of it
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        !$stable(node_index) |-> state == FETCH && $past(state) != FETCH)
        else $error("node_index moved without a FETCH wait cycle");

endmodule

`default_nettype wire

// ==== code_fifo.sv ====
/*
 * FIFO for the code stream between the walker and the codebook writer.
 * Valid/ready on both sides. Full after FIFO_DEPTH entries, and an entry
 * written on one edge shows on out_valid in the cycle after it.
 */
`timescale 1ns/1ps
`default_nettype none

module code_fifo
    import huff_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [CHAR_W-1:0] in_char,
    input  logic [CODE_W-1:0] in_bits,
    input  logic [LEN_W-1:0]  in_len,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [CHAR_W-1:0] out_char,
    output logic [CODE_W-1:0] out_bits,
    output logic [LEN_W-1:0]  out_len
);

    logic [CHAR_W-1:0]  char_mem [FIFO_DEPTH];
    logic [CODE_W-1:0]  bits_mem [FIFO_DEPTH];
    logic [LEN_W-1:0]   len_mem  [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               wr_en;
    logic               rd_en;

    assign in_ready  = (count != FIFO_CW'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;
    assign out_char  = char_mem[rd_ptr];  // head entry
    assign out_bits  = bits_mem[rd_ptr];
    assign out_len   = len_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            char_mem[wr_ptr] <= in_char;
            bits_mem[wr_ptr] <= in_bits;
            len_mem[wr_ptr]  <= in_len;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + FIFO_CW'(wr_en) - FIFO_CW'(rd_en);
        end
    end

    // a write refused while full is retried by the walker, not dropped
    a_full_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_char) && $stable(in_bits))
        else $error("entry lost while FIFO full");

    a_empty_ptr: assert property (@(posedge clk) disable iff (rst)
        count == '0 |-> wr_ptr == rd_ptr)
        else $error("FIFO pointers apart while empty");

endmodule

`default_nettype wire

// ==== codebook_writer.sv ====
/*
 * Codebook table, indexed by character. Accepted codes from the FIFO are
 * written together with a per-entry valid bit. clear wipes all valid bits in one cycle.
 * A lookup returns its result one cycle later and holds off writes while requested.
 */
`timescale 1ns/1ps
`default_nettype none

module codebook_writer
    import huff_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              out_valid,
    output logic              out_ready,
    input  logic [CHAR_W-1:0] out_char,
    input  logic [CODE_W-1:0] out_bits,
    input  logic [LEN_W-1:0]  out_len,
    input  logic              lookup_req,
    input  logic [CHAR_W-1:0] lookup_char,
    output logic              lookup_valid,
    output logic              lookup_hit,
    output logic [CODE_W-1:0] lookup_bits,
    output logic [LEN_W-1:0]  lookup_len
);

    logic [CODE_W-1:0]    code_tab [NUM_CHARS];
    logic [LEN_W-1:0]     len_tab  [NUM_CHARS];
    logic [NUM_CHARS-1:0] entry_valid;
    logic                 wr_en;

    assign out_ready = !lookup_req;  // lookup has priority
    assign wr_en     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            code_tab[out_char] <= out_bits;
            len_tab[out_char]  <= out_len;
        end
        if (lookup_req) begin
            lookup_bits <= code_tab[lookup_char];
            lookup_len  <= len_tab[lookup_char];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid  <= '0;
            lookup_valid <= 1'b0;
            lookup_hit   <= 1'b0;
        end else begin
            lookup_valid <= lookup_req;
            lookup_hit   <= lookup_req && entry_valid[lookup_char];
            if (clear) begin
                entry_valid <= '0;  // flash clear on a new walk
            end else if (wr_en) begin
                entry_valid[out_char] <= 1'b1;
            end
        end
    end

    // the walker visits each leaf once, so a character lands once per walk
    a_write_once: assert property (@(posedge clk) disable iff (rst)
        wr_en && !clear |-> !entry_valid[out_char])
        else $error("codebook entry written twice");

endmodule

`default_nettype wire

// ==== huff_codebook_top.sv ====
/*
 * Huffman codebook builder top level.
 * Load the tree through tree_we while busy is low, then pulse start with root_index.
 * Once done is high, read codes per character through the lookup port.
 */
`timescale 1ns/1ps
`default_nettype none

module huff_codebook_top
    import huff_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               tree_we,
    input  logic [NODE_AW-1:0] tree_waddr,
    input  logic [NODE_W-1:0]  tree_wdata,
    input  logic               start,
    input  logic [NODE_AW-1:0] root_index,
    output logic               busy,
    output logic               done,
    input  logic               lookup_req,
    input  logic [CHAR_W-1:0]  lookup_char,
    output logic               lookup_valid,
    output logic               lookup_hit,
    output logic [CODE_W-1:0]  lookup_bits,
    output logic [LEN_W-1:0]   lookup_len
);

    logic [NODE_AW-1:0] node_index;
    logic [NODE_W-1:0]  node_data;
    logic               start_accept;  // clears the codebook
    logic               code_valid;
    logic               code_ready;
    logic [CHAR_W-1:0]  code_char;
    logic [CODE_W-1:0]  code_bits;
    logic [LEN_W-1:0]   code_len;
    logic               out_valid;
    logic               out_ready;
    logic [CHAR_W-1:0]  out_char;
    logic [CODE_W-1:0]  out_bits;
    logic [LEN_W-1:0]   out_len;

    htree_ram u_ram (
        .clk        (clk),
        .tree_we    (tree_we),
        .tree_waddr (tree_waddr),
        .tree_wdata (tree_wdata),
        .node_index (node_index),
        .node_data  (node_data)
    );

    cb_synthesis u_walker (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .root_index   (root_index),
        .node_index   (node_index),
        .node_data    (node_data),
        .code_valid   (code_valid),
        .code_ready   (code_ready),
        .code_char    (code_char),
        .code_bits    (code_bits),
        .code_len     (code_len),
        .busy         (busy),
        .done         (done),
        .start_accept (start_accept)
    );

    code_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (code_valid),
        .in_ready  (code_ready),
        .in_char   (code_char),
        .in_bits   (code_bits),
        .in_len    (code_len),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_char  (out_char),
        .out_bits  (out_bits),
        .out_len   (out_len)
    );

    codebook_writer u_writer (
        .clk          (clk),
        .rst          (rst),
        .clear        (start_accept),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_char     (out_char),
        .out_bits     (out_bits),
        .out_len      (out_len),
        .lookup_req   (lookup_req),
        .lookup_char  (lookup_char),
        .lookup_valid (lookup_valid),
        .lookup_hit   (lookup_hit),
        .lookup_bits  (lookup_bits),
        .lookup_len   (lookup_len)
    );

endmodule

`default_nettype wire

// ==== tb_huff_codebook.sv ====
/*
 * Testbench for the Huffman codebook builder.
 * Builds a fixed tree and LFSR-driven random trees, loads them into the DUT, walks them
 * and sweeps the lookup port over all characters. A recursive reference walk sets the
 * expected codes, and concurrent assertions compare every lookup result with them.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_huff_codebook
    import huff_pkg::*;
;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_DEPTH    = 6;                           // deepest leaf, 63 nodes max
    localparam int MAX_LEAVES   = 1 << MAX_DEPTH;
    localparam int WALK_MAX     = MAX_LEAVES * (4 * MAX_DEPTH + 4);  // worst walk, cycles
    localparam int N_RANDOM     = 4;
    localparam int N_BURST      = 2;
    localparam int N_RUNS       = 4 + N_RANDOM + N_BURST;     // reset sweep, fixed, 2 restarts
    localparam int WATCHDOG_NS  = (N_RUNS * WALK_MAX * 4 + RESET_CYCLES) * CLK_PERIOD;

    logic               clk;
    logic               rst;
    logic               tree_we;
    logic [NODE_AW-1:0] tree_waddr;
    logic [NODE_W-1:0]  tree_wdata;
    logic               start;
    logic [NODE_AW-1:0] root_index;
    logic               busy;
    logic               done;
    logic               lookup_req;
    logic [CHAR_W-1:0]  lookup_char;
    logic               lookup_valid;
    logic               lookup_hit;
    logic [CODE_W-1:0]  lookup_bits;
    logic [LEN_W-1:0]   lookup_len;

    logic [NODE_W-1:0]    tree_img [NUM_NODES];  // tb copy of the tree
    int                   node_base;             // root sits here
    int                   node_cnt;
    logic [NUM_CHARS-1:0] char_used;
    logic [NUM_CHARS-1:0] exp_valid;             // reference codebook
    logic [CODE_W-1:0]    exp_bits [NUM_CHARS];
    logic [LEN_W-1:0]     exp_len  [NUM_CHARS];
    logic [15:0]          lfsr;
    logic                 full_chk;              // sweep lookups, misses are checked too
    logic                 full_q;
    logic                 exp_hit_q;
    logic [CODE_W-1:0]    exp_bits_q;
    logic [LEN_W-1:0]     exp_len_q;
    int                   err_cnt;
    int                   test_err_base;
    int                   pass_cnt;
    int                   fail_cnt;

    huff_codebook_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .tree_we      (tree_we),
        .tree_waddr   (tree_waddr),
        .tree_wdata   (tree_wdata),
        .start        (start),
        .root_index   (root_index),
        .busy         (busy),
        .done         (done),
        .lookup_req   (lookup_req),
        .lookup_char  (lookup_char),
        .lookup_valid (lookup_valid),
        .lookup_hit   (lookup_hit),
        .lookup_bits  (lookup_bits),
        .lookup_len   (lookup_len)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected result travels with the lookup, one cycle like the DUT
    always @(posedge clk) begin
        full_q     <= lookup_req && full_chk;
        exp_hit_q  <= exp_valid[lookup_char];
        exp_bits_q <= exp_bits[lookup_char];
        exp_len_q  <= exp_len[lookup_char];
    end

    task automatic flag_error(input string msg);
        $display("** Error at %t: %s", $time, msg);
        err_cnt++;
    endtask

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !busy && !done && !lookup_valid && u_dut.u_walker.state == INIT)
        else flag_error("DUT not idle when reset was released");

    a_lookup_hit: assert property (@(posedge clk) disable iff (rst)
        full_q |-> lookup_valid && lookup_hit == exp_hit_q)
        else flag_error("lookup_valid or lookup_hit differs from the reference codebook");

    // a hit is checked during the walk too, a partly built table may only miss
    a_lookup_code: assert property (@(posedge clk) disable iff (rst)
        lookup_valid && lookup_hit |-> exp_hit_q && lookup_bits == exp_bits_q
            && lookup_len == exp_len_q)
        else flag_error("lookup code or length differs from the reference");

    a_busy_end: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) || $rose(done) |-> $fell(busy) && $rose(done))
        else flag_error("busy and done did not change together at the end of a walk");

    a_start_clear: assert property (@(posedge clk) disable iff (rst)
        start && !busy |=> busy && !done)
        else flag_error("accepted start did not raise busy and clear done");

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);  // one step per bit
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [ENTRY_W-1:0] int_entry(input int idx);
        return {1'b1, {(ENTRY_W - 1 - NODE_AW){1'b0}}, idx[NODE_AW-1:0]};
    endfunction

    function automatic logic [ENTRY_W-1:0] leaf_entry(input logic [CHAR_W-1:0] ch);
        return {1'b0, ch};
    endfunction

    function automatic logic [CHAR_W-1:0] pick_char();
        int c;
        c = take_bits(CHAR_W);
        while (char_used[c]) begin
            c = (c + 1) % NUM_CHARS;  // next free character
        end
        char_used[c] = 1'b1;
        return c[CHAR_W-1:0];
    endfunction

    // random subtree, the top two levels are always internal
    function automatic logic [ENTRY_W-1:0] build_child(input int depth);
        int                 idx;
        logic [ENTRY_W-1:0] left_e;
        logic [ENTRY_W-1:0] right_e;
        if (depth < MAX_DEPTH && (depth < 2 || take_bits(1) == 1)) begin
            idx = node_base + node_cnt;
            node_cnt++;
            left_e  = build_child(depth + 1);
            right_e = build_child(depth + 1);
            tree_img[idx] = {left_e, right_e};
            return int_entry(idx);
        end
        return leaf_entry(pick_char());
    endfunction

    task automatic ref_walk(input int idx, input logic [CODE_W-1:0] code, input int len);
        logic [ENTRY_W-1:0] e;
        logic [CODE_W-1:0]  c;
        for (int side = 0; side < 2; side++) begin
            e = side ? tree_img[idx][RIGHT_LSB +: ENTRY_W] : tree_img[idx][LEFT_LSB +: ENTRY_W];
            c = (code << 1) | side;  // left 0, right 1, first move ends up msb
            if (e[INT_BIT]) begin
                ref_walk(e[NODE_AW-1:0], c, len + 1);
            end else begin
                exp_valid[e[CHAR_W-1:0]] = 1'b1;
                exp_bits[e[CHAR_W-1:0]]  = c;
                exp_len[e[CHAR_W-1:0]]   = LEN_W'(len + 1);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic prepare_tree();
        for (int i = 0; i < node_cnt; i++) begin
            tree_we    = 1'b1;
            tree_waddr = NODE_AW'(node_base + i);
            tree_wdata = tree_img[node_base + i];
            next_cycle();
        end
        tree_we   = 1'b0;
        exp_valid = '0;
        for (int c = 0; c < NUM_CHARS; c++) begin
            exp_bits[c] = '0;
            exp_len[c]  = '0;
        end
        ref_walk(node_base, '0, 0);
    endtask

    task automatic make_random_tree();
        char_used = '0;
        node_cnt  = 0;
        node_base = take_bits(6);  // keeps every index below NUM_NODES
        void'(build_child(0));     // root lands at node_base
        prepare_tree();
    endtask

    task automatic run_walk(input bit bursts, input bit poke);
        int cycles;
        int burst_left;
        cycles     = 0;
        burst_left = 0;
        start      = 1'b1;
        root_index = NODE_AW'(node_base);
        next_cycle();
        start = 1'b0;
        while (!done && cycles < 2 * WALK_MAX) begin
            if (bursts) begin
                if (burst_left == 0 && take_bits(1) == 1) begin
                    burst_left = take_bits(3) + 1;  // up to 8 cycles of lookups
                end
                lookup_req  = (burst_left != 0);
                lookup_char = CHAR_W'(take_bits(CHAR_W));
                if (burst_left != 0) begin
                    burst_left--;
                end
            end
            start = poke && cycles == 3;  // start while busy, must be ignored
            next_cycle();
            cycles++;
        end
        lookup_req = 1'b0;
        start      = 1'b0;
        if (!done) begin
            $display("walk from root %0d did not reach done within %0d cycles", node_base, cycles);
            err_cnt++;
        end
    endtask

    task automatic sweep_codebook();
        repeat (FIFO_DEPTH + 2) next_cycle();  // FIFO empties into the table
        full_chk = 1'b1;
        for (int c = 0; c < NUM_CHARS; c++) begin
            lookup_req  = 1'b1;
            lookup_char = CHAR_W'(c);
            next_cycle();
        end
        lookup_req = 1'b0;
        full_chk   = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, a walk or a sweep never finished", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst           = 1'b1;
        tree_we       = 1'b0;
        tree_waddr    = '0;
        tree_wdata    = '0;
        start         = 1'b0;
        root_index    = '0;
        lookup_req    = 1'b0;
        lookup_char   = '0;
        full_chk      = 1'b0;
        lfsr          = 16'd57;
        exp_valid     = '0;
        err_cnt       = 0;
        test_err_base = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        sweep_codebook();  // empty table after reset
        end_test("reset state");

        node_base    = 10;
        node_cnt     = 4;
        tree_img[10] = {int_entry(11), leaf_entry(8'h45)};     // E = 1
        tree_img[11] = {leaf_entry(8'h41), int_entry(12)};     // A = 00
        tree_img[12] = {int_entry(13), leaf_entry(8'h44)};     // D = 011
        tree_img[13] = {leaf_entry(8'h42), leaf_entry(8'h43)}; // B = 0100, C = 0101
        prepare_tree();
        run_walk(1'b0, 1'b0);
        sweep_codebook();
        end_test("fixed five leaf tree");

        repeat (N_RANDOM) begin
            make_random_tree();
            run_walk(1'b0, 1'b0);
            sweep_codebook();
        end
        end_test("random trees");

        repeat (N_BURST) begin
            make_random_tree();
            run_walk(1'b1, 1'b0);  // lookups stall the writer
            sweep_codebook();
        end
        end_test("lookup bursts during walk");

        make_random_tree();
        run_walk(1'b0, 1'b0);
        sweep_codebook();
        make_random_tree();
        run_walk(1'b0, 1'b1);  // old entries must be gone
        sweep_codebook();
        end_test("restart with new tree");

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
huff_pkg.sv
htree_ram.sv
cb_synthesis.sv
code_fifo.sv
codebook_writer.sv
huff_codebook_top.sv
tb_huff_codebook.sv

// ==== Bender.yml ====
package:
  name: huff_codebook

sources:
  - huff_pkg.sv
  - htree_ram.sv
  - cb_synthesis.sv
  - code_fifo.sv
  - codebook_writer.sv
  - huff_codebook_top.sv
  - target: test
    files:
      - tb_huff_codebook.sv
